/* wbuf.f */
+incdir+.
wbuf_pkg.sv
wbuf_dir.sv
wbuf_data.sv
wbuf_send.sv
wbuf_top.sv
wbuf_tb.sv

/* wbuf_tb.sv */
/*
 * Testbench for the write buffer top level.
 * Test tags must differ in their low four bits while they are in flight,
 * so WBUF_DIR_ENTRIES may not exceed 7 here.
 * Every sent line is acknowledged ACK_DELAY cycles after its transfer.
 */
`timescale 1ns/1ns
`include "wbuf_params.svh"

module wbuf_tb
    import wbuf_pkg::*;
();

    // Limit set well above the few hundred cycles that the tests take
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int ACK_DELAY      = 4;
    // Flush sends all open lines before the oldest timer could close one
    localparam int FLUSH_WINDOW   = 6;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             wr;
    logic             wr_ready;
    wbuf_addr_u       wr_addr;
    wbuf_word_t       wr_data;
    wbuf_be_t         wr_be;
    logic             wr_uc;
    wbuf_timecnt_t    threshold;
    logic             flush;
    logic             snd_valid;
    logic             snd_ready;
    wbuf_dir_ptr_t    snd_id;
    wbuf_addr_u       snd_addr;
    wbuf_line_data_t  snd_data;
    wbuf_line_be_t    snd_be;
    logic             snd_uc;
    logic             ack;
    wbuf_dir_ptr_t    ack_id;
    logic             empty;
    logic             full;

    // Model lines indexed by the low four tag bits
    logic             m_valid [16];
    wbuf_tag_t        m_tag [16];
    wbuf_line_data_t  m_data [16];
    wbuf_line_be_t    m_be [16];
    logic             m_uc [16];
    logic             busy [16];
    int               slot_key [`WBUF_DIR_ENTRIES];
    int               ack_due [`WBUF_DIR_ENTRIES];

    int           cycles = 0;
    int           n_sends = 0;
    int           n_mismatch = 0;
    int           n_fail = 0;
    logic [31:0]  rng_state = 32'h936f;

    always #2 clk = ~clk;

    wbuf_top i_dut (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .write_i         (wr),
        .write_ready_o   (wr_ready),
        .write_addr_i    (wr_addr),
        .write_data_i    (wr_data),
        .write_be_i      (wr_be),
        .write_uc_i      (wr_uc),
        .cfg_threshold_i (threshold),
        .flush_all_i     (flush),
        .send_valid_o    (snd_valid),
        .send_ready_i    (snd_ready),
        .send_id_o       (snd_id),
        .send_addr_o     (snd_addr),
        .send_data_o     (snd_data),
        .send_be_o       (snd_be),
        .send_uc_o       (snd_uc),
        .ack_i           (ack),
        .ack_id_i        (ack_id),
        .empty_o         (empty),
        .full_o          (full)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Expected line after one word write
    function automatic wbuf_line_data_t ref_merge(input wbuf_line_data_t line, input int widx,
                                                  input wbuf_word_t word, input wbuf_be_t be);
        wbuf_line_data_t res;
        res = line;
        for (int b = 0; b < WBUF_BYTES; b++) begin
            if (be[b]) begin
                res[widx][b*8 +: 8] = word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // Low nibble of the tag equals n
    function automatic wbuf_tag_t test_tag(input int n);
        return wbuf_tag_t'(32'h5a30 + n);
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        n_mismatch++;
    endtask

    task automatic report_failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        n_fail++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Offer one random word until the DUT takes it
    task automatic write_word(input int n, input int widx, input logic uc, output int stalls);
        wbuf_addr_u addr;
        addr.raw    = '0;
        addr.f.tag  = test_tag(n);
        addr.f.widx = WBUF_WIDX_WIDTH'(widx);
        wr      = 1'b1;
        wr_addr = addr;
        wr_data = wbuf_word_t'(next_rand());
        wr_be   = wbuf_be_t'(next_rand());
        if (wr_be == '0) begin
            wr_be = wbuf_be_t'(1);
        end
        wr_uc  = uc;
        stalls = 0;
        @(negedge clk);
        while (!wr_ready) begin
            stalls++;
            @(negedge clk);
        end
        next_cycle();
        wr = 1'b0;
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (!empty);
        next_cycle();
    endtask

    always @(posedge clk) begin : watchdog
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // Returns each sent id once its due cycle comes up
    initial begin : ack_driver
        ack    = 1'b0;
        ack_id = '0;
        forever begin
            next_cycle();
            ack = 1'b0;
            for (int i = 0; i < `WBUF_DIR_ENTRIES; i++) begin
                if (ack_due[i] == cycles) begin
                    ack    = 1'b1;
                    ack_id = wbuf_dir_ptr_t'(i);
                end
            end
        end
    end

    // Sampled at the falling edge halfway between input changes
    initial begin : monitor
        int               k;
        logic             held;
        wbuf_dir_ptr_t    held_id;
        wbuf_addr_u       held_addr;
        wbuf_line_data_t  held_data;
        wbuf_line_be_t    held_be;
        logic             held_uc;
        for (int i = 0; i < 16; i++) begin
            m_valid[i] = 1'b0;
            busy[i]    = 1'b0;
        end
        for (int i = 0; i < `WBUF_DIR_ENTRIES; i++) begin
            ack_due[i]  = -1;
            slot_key[i] = 0;
        end
        held      = 1'b0;
        held_id   = '0;
        held_addr = '0;
        held_data = '0;
        held_be   = '0;
        held_uc   = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (wr && wr_ready) begin
                    k = int'(wr_addr.f.tag[3:0]);
                    if (busy[k]) begin
                        report_failure("write accepted on a sent line before its ack");
                    end
                    if (!m_valid[k]) begin
                        m_valid[k] = 1'b1;
                        m_tag[k]   = wr_addr.f.tag;
                        m_data[k]  = '0;
                        m_be[k]    = '0;
                        m_uc[k]    = wr_uc;
                    end
                    m_data[k] = ref_merge(m_data[k], int'(wr_addr.f.widx), wr_data, wr_be);
                    m_be[k][wr_addr.f.widx] = m_be[k][wr_addr.f.widx] | wr_be;
                end
                if (held && (!snd_valid || (snd_id != held_id) || (snd_addr != held_addr)
                             || (snd_data != held_data) || (snd_be != held_be)
                             || (snd_uc != held_uc))) begin
                    report_failure("send_valid_o dropped or the offered line changed");
                end
                held      = snd_valid && !snd_ready;
                held_id   = snd_id;
                held_addr = snd_addr;
                held_data = snd_data;
                held_be   = snd_be;
                held_uc   = snd_uc;
                if (snd_valid && snd_ready) begin
                    k = int'(snd_addr.f.tag[3:0]);
                    n_sends++;
                    if (!m_valid[k] || (m_tag[k] != snd_addr.f.tag)) begin
                        report_failure($sformatf("send of tag %h that holds no write",
                                                 snd_addr.f.tag));
                    end else begin
                        if ((snd_addr.f.widx != '0) || (snd_addr.f.boff != '0)) begin
                            report_mismatch($sformatf("send address %h has a line offset",
                                                      snd_addr.raw));
                        end
                        if (snd_data != m_data[k]) begin
                            report_mismatch($sformatf("tag %h data %h, expected %h",
                                                      m_tag[k], snd_data, m_data[k]));
                        end
                        if (snd_be != m_be[k]) begin
                            report_mismatch($sformatf("tag %h mask %b, expected %b",
                                                      m_tag[k], snd_be, m_be[k]));
                        end
                        if (snd_uc != m_uc[k]) begin
                            report_mismatch($sformatf("tag %h uc %b, expected %b",
                                                      m_tag[k], snd_uc, m_uc[k]));
                        end
                        m_valid[k]       = 1'b0;
                        busy[k]          = 1'b1;
                        slot_key[snd_id] = k;
                        ack_due[snd_id]  = cycles + ACK_DELAY;
                    end
                end
                if (ack) begin
                    busy[slot_key[ack_id]] = 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        int base;
        int stalls;
        int flush_wait;
        rst_n     = 1'b0;
        wr        = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        wr_be     = '0;
        wr_uc     = 1'b0;
        threshold = '1;
        flush     = 1'b0;
        snd_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (!empty || full || snd_valid) begin
            report_mismatch($sformatf("after reset empty=%b full=%b send_valid=%b",
                                      empty, full, snd_valid));
        end
        next_cycle();

        // Two words of one line inside the timer window
        base = n_sends;
        write_word(0, 0, 1'b0, stalls);
        write_word(0, 1, 1'b0, stalls);
        wait_idle();
        if (n_sends != base + 1) begin
            report_mismatch($sformatf("coalescing gave %0d sends, expected 1", n_sends - base));
        end

        // Threshold 0, then uncacheable writes under a long threshold
        base      = n_sends;
        threshold = '0;
        write_word(1, 0, 1'b0, stalls);
        write_word(1, 1, 1'b1, stalls);
        write_word(3, 1, 1'b0, stalls);
        threshold = '1;
        write_word(2, 0, 1'b1, stalls);
        write_word(2, 1, 1'b1, stalls);
        wait_idle();
        if (n_sends != base + 5) begin
            report_mismatch($sformatf("immediate sends %0d, expected 5", n_sends - base));
        end

        // Open lines leave only on flush
        base = n_sends;
        for (int i = 4; i < 7; i++) begin
            write_word(i, i % 2, 1'b0, stalls);
        end
        if (n_sends != base) begin
            report_mismatch("open line sent before its timer or a flush");
        end
        flush      = 1'b1;
        flush_wait = 0;
        while ((n_sends != base + 3) && (flush_wait < FLUSH_WINDOW)) begin
            @(negedge clk);
            flush_wait++;
        end
        if (n_sends != base + 3) begin
            report_mismatch($sformatf("flush sent %0d lines within %0d cycles, expected 3",
                                      n_sends - base, FLUSH_WINDOW));
        end
        wait_idle();
        flush = 1'b0;
        if (n_sends != base + 3) begin
            report_mismatch($sformatf("flush gave %0d sends, expected 3", n_sends - base));
        end

        // Write to a sent line waits for its ack
        threshold = '0;
        write_word(7, 0, 1'b0, stalls);
        do begin
            @(negedge clk);
        end while (!busy[7]);
        next_cycle();
        write_word(7, 1, 1'b0, stalls);
        if (stalls == 0) begin
            report_failure("write to a sent line was taken without waiting for the ack");
        end
        wait_idle();

        // Back-pressure until every slot is used
        base      = n_sends;
        snd_ready = 1'b0;
        for (int i = 0; i < `WBUF_DIR_ENTRIES; i++) begin
            write_word(8 + i, 0, 1'b0, stalls);
        end
        @(negedge clk);
        if (!full) begin
            report_mismatch("full_o low with every slot in use");
        end
        next_cycle();
        wr              = 1'b1;
        wr_addr.raw     = '0;
        wr_addr.f.tag   = test_tag(8 + `WBUF_DIR_ENTRIES);
        wr_data         = wbuf_word_t'(next_rand());
        wr_be           = '1;
        wr_uc           = 1'b0;
        repeat (3) begin
            @(negedge clk);
            if (wr_ready) begin
                report_mismatch("write_ready_o high for a new line while full");
            end
        end
        next_cycle();
        wr        = 1'b0;
        snd_ready = 1'b1;
        wait_idle();
        if (n_sends != base + `WBUF_DIR_ENTRIES) begin
            report_mismatch($sformatf("full test gave %0d sends, expected %0d",
                                      n_sends - base, `WBUF_DIR_ENTRIES));
        end
        @(negedge clk);
        if (!empty || full) begin
            report_mismatch($sformatf("after drain empty=%b full=%b", empty, full));
        end

        for (int i = 0; i < 16; i++) begin
            if (m_valid[i]) begin
                report_failure($sformatf("line with tag %h was written but never sent",
                                         m_tag[i]));
            end
        end

        $display("Checks done: %0d mismatches, %0d other errors", n_mismatch, n_fail);
        if ((n_mismatch == 0) && (n_fail == 0)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* wbuf_top.sv */
/*
 * Write buffer top level.
 * Writes are taken when write_i and write_ready_o are both high.
 * Lines leave on a valid/ready channel and stay owned until ack_i names them.
 * cfg_threshold_i and flush_all_i are sampled every cycle as levels.
 */
`timescale 1ns/1ns
`include "wbuf_params.svh"

module wbuf_top
    import wbuf_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             write_i,
    output logic             write_ready_o,
    input  wbuf_addr_u       write_addr_i,
    input  wbuf_word_t       write_data_i,
    input  wbuf_be_t         write_be_i,
    input  logic             write_uc_i,
    input  wbuf_timecnt_t    cfg_threshold_i,
    input  logic             flush_all_i,
    output logic             send_valid_o,
    input  logic             send_ready_i,
    output wbuf_dir_ptr_t    send_id_o,
    output wbuf_addr_u       send_addr_o,
    output wbuf_line_data_t  send_data_o,
    output wbuf_line_be_t    send_be_o,
    output logic             send_uc_o,
    input  logic             ack_i,
    input  wbuf_dir_ptr_t    ack_id_i,
    output logic             empty_o,
    output logic             full_o
);

    logic                                 merge;
    logic                                 merge_clear;
    wbuf_dir_ptr_t                        merge_slot;
    wbuf_line_be_t                        merge_be;
    wbuf_state_e [`WBUF_DIR_ENTRIES-1:0]  dir_state;
    wbuf_tag_t [`WBUF_DIR_ENTRIES-1:0]    dir_tag;
    logic [`WBUF_DIR_ENTRIES-1:0]         dir_uc;
    logic                                 sent;
    wbuf_dir_ptr_t                        sent_slot;

    wbuf_dir i_dir (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .write_i         (write_i),
        .write_addr_i    (write_addr_i),
        .write_be_i      (write_be_i),
        .write_uc_i      (write_uc_i),
        .flush_all_i     (flush_all_i),
        .cfg_threshold_i (cfg_threshold_i),
        .sent_i          (sent),
        .sent_slot_i     (sent_slot),
        .ack_i           (ack_i),
        .ack_id_i        (ack_id_i),
        .write_ready_o   (write_ready_o),
        .merge_o         (merge),
        .merge_clear_o   (merge_clear),
        .merge_slot_o    (merge_slot),
        .merge_be_o      (merge_be),
        .state_o         (dir_state),
        .tag_o           (dir_tag),
        .uc_o            (dir_uc),
        .empty_o         (empty_o),
        .full_o          (full_o)
    );

    // The offered slot's line is read straight from storage
    wbuf_data i_data (
        .clk_i         (clk_i),
        .merge_i       (merge),
        .merge_clear_i (merge_clear),
        .merge_slot_i  (merge_slot),
        .merge_be_i    (merge_be),
        .write_data_i  (write_data_i),
        .read_slot_i   (send_id_o),
        .read_data_o   (send_data_o),
        .read_be_o     (send_be_o)
    );

    wbuf_send i_send (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .state_i      (dir_state),
        .tag_i        (dir_tag),
        .uc_i         (dir_uc),
        .send_ready_i (send_ready_i),
        .send_valid_o (send_valid_o),
        .send_id_o    (send_id_o),
        .send_addr_o  (send_addr_o),
        .send_uc_o    (send_uc_o),
        .sent_o       (sent),
        .sent_slot_o  (sent_slot)
    );

endmodule

/* wbuf_send.sv */
/*
 * Send side of the write buffer.
 * A round-robin pointer walks the pending slots and offers the one it rests on.
 * Once offered, a slot stays on the channel unchanged until send_ready_i.
 */
`timescale 1ns/1ns
`include "wbuf_params.svh"

module wbuf_send
    import wbuf_pkg::*;
(
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  wbuf_state_e [`WBUF_DIR_ENTRIES-1:0]  state_i,
    input  wbuf_tag_t [`WBUF_DIR_ENTRIES-1:0]    tag_i,
    input  logic [`WBUF_DIR_ENTRIES-1:0]         uc_i,
    input  logic                                 send_ready_i,
    output logic                                 send_valid_o,
    output wbuf_dir_ptr_t                        send_id_o,
    output wbuf_addr_u                           send_addr_o,
    output logic                                 send_uc_o,
    output logic                                 sent_o,
    output wbuf_dir_ptr_t                        sent_slot_o
);

    logic [`WBUF_DIR_ENTRIES-1:0]  pend_vec;
    wbuf_dir_ptr_t                 send_ptr_q, send_ptr_d;
    logic                          xfer;

    always_comb begin : pend_comb
        for (int i = 0; i < `WBUF_DIR_ENTRIES; i++) begin
            pend_vec[i] = (state_i[i] == WBUF_PEND);
        end
    end

    assign send_valid_o = pend_vec[send_ptr_q];
    assign xfer         = send_valid_o && send_ready_i;

    // Hold on an offered slot, else move on to the next pending one
    assign send_ptr_d = (send_valid_o && !send_ready_i) ? send_ptr_q
                                                        : wbuf_find_next(send_ptr_q, pend_vec);

    always_ff @(posedge clk_i or negedge rst_ni) begin : ptr_ff
        if (!rst_ni) begin
            send_ptr_q <= '0;
        end else begin
            send_ptr_q <= send_ptr_d;
        end
    end

    // Line address with the offset bits cleared
    assign send_addr_o.raw = {tag_i[send_ptr_q], {WBUF_OFFSET_WIDTH{1'b0}}};
    assign send_id_o       = send_ptr_q;
    assign send_uc_o       = uc_i[send_ptr_q];

    assign sent_o      = xfer;
    assign sent_slot_o = send_ptr_q;

endmodule

/* wbuf_data.sv */
/*
 * Line storage, one data line and one byte mask per slot.
 * No reset: a slot's content is only valid after its first merge.
 * The read port is combinational and serves the send channel.
 */
`timescale 1ns/1ns
`include "wbuf_params.svh"

module wbuf_data
    import wbuf_pkg::*;
(
    input  logic             clk_i,
    input  logic             merge_i,
    input  logic             merge_clear_i,
    input  wbuf_dir_ptr_t    merge_slot_i,
    input  wbuf_line_be_t    merge_be_i,
    input  wbuf_word_t       write_data_i,
    input  wbuf_dir_ptr_t    read_slot_i,
    output wbuf_line_data_t  read_data_o,
    output wbuf_line_be_t    read_be_o
);

    wbuf_line_data_t  line_q [`WBUF_DIR_ENTRIES];
    wbuf_line_be_t    mask_q [`WBUF_DIR_ENTRIES];

    wbuf_line_data_t  rep_data;
    wbuf_line_data_t  old_data;
    wbuf_line_be_t    old_be;
    wbuf_line_data_t  new_data;
    wbuf_line_be_t    new_be;

    // Same word in every lane so the mask picks the lane
    assign rep_data = {`WBUF_WORDS{write_data_i}};

    // A freshly allocated slot starts from an empty line
    assign old_data = merge_clear_i ? '0 : line_q[merge_slot_i];
    assign old_be   = merge_clear_i ? '0 : mask_q[merge_slot_i];

    always_comb begin : merge_comb
        for (int w = 0; w < `WBUF_WORDS; w++) begin
            for (int b = 0; b < WBUF_BYTES; b++) begin
                new_data[w][b*8 +: 8] = merge_be_i[w][b] ? rep_data[w][b*8 +: 8]
                                                         : old_data[w][b*8 +: 8];
            end
        end
        new_be = old_be | merge_be_i;
    end

    always_ff @(posedge clk_i) begin : line_ff
        if (merge_i) begin
            line_q[merge_slot_i] <= new_data;
            mask_q[merge_slot_i] <= new_be;
        end
    end

    assign read_data_o = line_q[read_slot_i];
    assign read_be_o   = mask_q[read_slot_i];

endmodule

/* wbuf_dir.sv */
/*
 * Slot directory of the write buffer.
 * A write that hits an open line merges, one that hits a pending or sent line
 * stalls until that slot is acknowledged, any other write takes a free slot.
 * ack_id_i must name a sent slot. A threshold of 0 sends every write alone.
 */
`timescale 1ns/1ns
`include "wbuf_params.svh"

module wbuf_dir
    import wbuf_pkg::*;
(
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 write_i,
    input  wbuf_addr_u                           write_addr_i,
    input  wbuf_be_t                             write_be_i,
    input  logic                                 write_uc_i,
    input  logic                                 flush_all_i,
    input  wbuf_timecnt_t                        cfg_threshold_i,
    input  logic                                 sent_i,
    input  wbuf_dir_ptr_t                        sent_slot_i,
    input  logic                                 ack_i,
    input  wbuf_dir_ptr_t                        ack_id_i,
    output logic                                 write_ready_o,
    output logic                                 merge_o,
    output logic                                 merge_clear_o,
    output wbuf_dir_ptr_t                        merge_slot_o,
    output wbuf_line_be_t                        merge_be_o,
    output wbuf_state_e [`WBUF_DIR_ENTRIES-1:0]  state_o,
    output wbuf_tag_t [`WBUF_DIR_ENTRIES-1:0]    tag_o,
    output logic [`WBUF_DIR_ENTRIES-1:0]         uc_o,
    output logic                                 empty_o,
    output logic                                 full_o
);

    wbuf_state_e [`WBUF_DIR_ENTRIES-1:0]    state_q, state_d;
    wbuf_timecnt_t [`WBUF_DIR_ENTRIES-1:0]  cnt_q, cnt_d;
    wbuf_tag_t [`WBUF_DIR_ENTRIES-1:0]      tag_q;
    logic [`WBUF_DIR_ENTRIES-1:0]           uc_q;
    logic [`WBUF_DIR_ENTRIES-1:0]           free_vec;
    wbuf_dir_ptr_t                          free_ptr_q, free_ptr_d;

    wbuf_tag_t      write_tag;
    logic           hit_open;
    logic           hit_busy;
    wbuf_dir_ptr_t  hit_ptr;
    logic           alloc_ok;
    logic           alloc;
    logic           close_now;
    wbuf_timecnt_t  thr_m1;

    assign write_tag = write_addr_i.f.tag;
    assign thr_m1    = cfg_threshold_i - 1'b1;

    // Look the write tag up among the used slots
    always_comb begin : hit_comb
        hit_open = 1'b0;
        hit_busy = 1'b0;
        hit_ptr  = '0;
        for (int i = 0; i < `WBUF_DIR_ENTRIES; i++) begin
            if ((state_q[i] != WBUF_FREE) && (tag_q[i] == write_tag)) begin
                if (state_q[i] == WBUF_OPEN) begin
                    hit_open = 1'b1;
                    hit_ptr  = wbuf_dir_ptr_t'(i);
                end else begin
                    hit_busy = 1'b1;
                end
            end
        end
    end

    always_comb begin : free_vec_comb
        for (int i = 0; i < `WBUF_DIR_ENTRIES; i++) begin
            free_vec[i] = (state_q[i] == WBUF_FREE);
        end
    end

    assign alloc_ok      = !hit_open && !hit_busy && free_vec[free_ptr_q];
    assign write_ready_o = hit_open || alloc_ok;
    assign alloc         = write_i && alloc_ok;
    assign close_now     = (cfg_threshold_i == '0) || write_uc_i || flush_all_i;

    // Merge request toward the line storage
    assign merge_o       = write_i && write_ready_o;
    assign merge_clear_o = !hit_open;
    assign merge_slot_o  = hit_open ? hit_ptr : free_ptr_q;

    always_comb begin : be_widen_comb
        for (int w = 0; w < `WBUF_WORDS; w++) begin
            merge_be_o[w] = (w == int'(write_addr_i.f.widx)) ? write_be_i : '0;
        end
    end

    // An ack always frees a slot, so jump there
    always_comb begin : free_ptr_comb
        free_ptr_d = free_ptr_q;
        if (ack_i) begin
            free_ptr_d = ack_id_i;
        end else if (alloc) begin
            free_ptr_d = wbuf_find_next(free_ptr_q, free_vec);
        end
    end

    always_comb begin : state_comb
        state_d = state_q;
        cnt_d   = cnt_q;
        for (int i = 0; i < `WBUF_DIR_ENTRIES; i++) begin
            case (state_q[i])
                WBUF_FREE: begin
                    if (alloc && (wbuf_dir_ptr_t'(i) == free_ptr_q)) begin
                        state_d[i] = close_now ? WBUF_PEND : WBUF_OPEN;
                        cnt_d[i]   = '0;
                    end
                end
                WBUF_OPEN: begin
                    if (flush_all_i || (cnt_q[i] == thr_m1)) begin
                        state_d[i] = WBUF_PEND;
                    end else begin
                        cnt_d[i] = cnt_q[i] + 1'b1;
                    end
                end
                WBUF_PEND: begin
                    if (sent_i && (sent_slot_i == wbuf_dir_ptr_t'(i))) begin
                        state_d[i] = WBUF_SENT;
                    end
                end
                WBUF_SENT: begin
                    if (ack_i && (ack_id_i == wbuf_dir_ptr_t'(i))) begin
                        state_d[i] = WBUF_FREE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_ff
        if (!rst_ni) begin
            state_q    <= {`WBUF_DIR_ENTRIES{WBUF_FREE}};
            cnt_q      <= '0;
            free_ptr_q <= '0;
        end else begin
            state_q    <= state_d;
            cnt_q      <= cnt_d;
            free_ptr_q <= free_ptr_d;
        end
    end

    // Tag and uncacheable flag of each allocated line
    always_ff @(posedge clk_i) begin : ident_ff
        if (alloc) begin
            tag_q[free_ptr_q] <= write_tag;
            uc_q[free_ptr_q]  <= write_uc_i;
        end
    end

    assign state_o = state_q;
    assign tag_o   = tag_q;
    assign uc_o    = uc_q;
    assign empty_o = &free_vec;
    assign full_o  = ~|free_vec;

endmodule

/* wbuf_pkg.sv */
/*
 * Types shared by the write buffer blocks.
 * The address union splits an address into tag, word index and byte offset.
 * Pointer arithmetic wraps, so the slot count must be a power of two.
 */
`include "wbuf_params.svh"

package wbuf_pkg;

    localparam int unsigned WBUF_BYTES          = `WBUF_WORD_WIDTH / 8;
    localparam int unsigned WBUF_BYTE_OFF_WIDTH = $clog2(WBUF_BYTES);
    localparam int unsigned WBUF_WIDX_WIDTH     = $clog2(`WBUF_WORDS);
    localparam int unsigned WBUF_OFFSET_WIDTH   = WBUF_WIDX_WIDTH + WBUF_BYTE_OFF_WIDTH;
    localparam int unsigned WBUF_TAG_WIDTH      = `WBUF_PA_WIDTH - WBUF_OFFSET_WIDTH;
    localparam int unsigned WBUF_DIR_PTR_WIDTH  = $clog2(`WBUF_DIR_ENTRIES);

    // Slot life cycle
    typedef enum logic [1:0] {
        WBUF_FREE = 2'b00,
        WBUF_OPEN = 2'b01,
        WBUF_PEND = 2'b10,
        WBUF_SENT = 2'b11
    } wbuf_state_e;

    typedef logic [WBUF_DIR_PTR_WIDTH-1:0]  wbuf_dir_ptr_t;
    typedef logic [WBUF_TAG_WIDTH-1:0]      wbuf_tag_t;

    typedef struct packed {
        wbuf_tag_t                       tag;
        logic [WBUF_WIDX_WIDTH-1:0]      widx;
        logic [WBUF_BYTE_OFF_WIDTH-1:0]  boff;
    } wbuf_addr_fields_t;

    // Same address, seen raw or split into fields
    typedef union packed {
        logic [`WBUF_PA_WIDTH-1:0]  raw;
        wbuf_addr_fields_t          f;
    } wbuf_addr_u;

    typedef logic [`WBUF_WORD_WIDTH-1:0]     wbuf_word_t;
    typedef logic [WBUF_BYTES-1:0]           wbuf_be_t;
    typedef wbuf_word_t [`WBUF_WORDS-1:0]    wbuf_line_data_t;
    typedef wbuf_be_t [`WBUF_WORDS-1:0]      wbuf_line_be_t;
    typedef logic [`WBUF_TIMECNT_WIDTH-1:0]  wbuf_timecnt_t;

    // Next slot after curr whose bit is set, or curr itself when none is
    function automatic wbuf_dir_ptr_t wbuf_find_next(
            input wbuf_dir_ptr_t                 curr,
            input logic [`WBUF_DIR_ENTRIES-1:0]  hit);
        wbuf_dir_ptr_t nxt;
        wbuf_dir_ptr_t cand;
        nxt = curr;
        // Walk from the farthest slot down so the nearest one wins
        for (int k = `WBUF_DIR_ENTRIES - 1; k >= 1; k--) begin
            cand = curr + wbuf_dir_ptr_t'(k);
            if (hit[cand]) begin
                nxt = cand;
            end
        end
        return nxt;
    endfunction

endpackage

/* wbuf_params.svh */
/*
 * Write buffer sizing macros, shared by the package and the RTL.
 * WBUF_DIR_ENTRIES and WBUF_WORDS must be powers of two, 2 or more.
 * WBUF_WORD_WIDTH must be a multiple of 8.
 * WBUF_TIMECNT_WIDTH bounds the largest usable timer threshold.
 */
`ifndef WBUF_PARAMS_SVH
`define WBUF_PARAMS_SVH

// Number of line slots
`define WBUF_DIR_ENTRIES 4

// Width of one write word, in bits
`define WBUF_WORD_WIDTH 32

// Words per buffered line
`define WBUF_WORDS 2

// Physical address width
`define WBUF_PA_WIDTH 32

// Width of the slot timer and of the threshold
`define WBUF_TIMECNT_WIDTH 3

`endif
